/* eth_pkg.sv */
`default_nettype none

package eth_pkg;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_HEADER,
		TX_PAYLOAD,
		TX_FCS,
		TX_GAP
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_HEADER,
		RX_PAYLOAD,
		RX_TAIL,
		RX_GAP
	} rx_state_t;

	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;
	localparam int PREAMBLE_LEN = 8; // Includes the SFD.
	localparam int HEADER_LEN = 14;
	localparam int MIN_PAYLOAD = 46;
	localparam int FCS_LEN = 4;
	localparam int GAP_LEN = 12;
	localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3; // Register after a good FCS.

endpackage

`default_nettype wire

/* crc32_d8.sv */
`timescale 1ns/1ns
`default_nettype none

module crc32_d8 (
	input  logic        clk,
	input  logic        reset,
	input  logic        clear,
	input  logic        en,
	input  logic [7:0]  d,
	output logic [31:0] crc,
	output logic        residue_ok
);
	import eth_pkg::*;

	localparam logic [31:0] POLY = 32'hEDB88320; // Reflected IEEE 802.3.

	logic [31:0] r;

	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] x;
		x = c ^ {24'h000000, b};
		for (int i = 0; i < 8; i++) begin
			x = x[0] ? ((x >> 1) ^ POLY) : (x >> 1); // LSB first.
		end
		return x;
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			r <= '1;
		end else if (clear) begin
			r <= '1;
		end else if (en) begin
			r <= crc_step(r, d);
		end
	end

	assign crc = ~r;
	assign residue_ok = (r == CRC_RESIDUE);

endmodule

`default_nettype wire

/* tx_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module tx_fifo #(
	parameter int FIFO_AW = 5
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       wr_en,
	input  logic [7:0] wr_data,
	input  logic       rd_en,
	output logic [7:0] rd_data,
	output logic       empty
);

	localparam int DEPTH = 1 << FIFO_AW;

	logic [7:0] mem [DEPTH];
	logic [FIFO_AW:0] wptr;
	logic [FIFO_AW:0] rptr;
	logic full;

	assign empty = (wptr == rptr);
	assign full = (wptr[FIFO_AW] != rptr[FIFO_AW]) &&
		(wptr[FIFO_AW-1:0] == rptr[FIFO_AW-1:0]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (wr_en && !full)
				wptr <= wptr + 1'b1;
			if (rd_en && !empty)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && !full)
			mem[wptr[FIFO_AW-1:0]] <= wr_data;
		if (rd_en && !empty)
			rd_data <= mem[rptr[FIFO_AW-1:0]]; // Block RAM style read.
	end

endmodule

`default_nettype wire

/* gmii_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module gmii_tx (
	input  logic        clk,
	input  logic        reset,
	input  logic        tx_valid,
	input  logic [47:0] tx_dmac,
	input  logic [47:0] tx_smac,
	input  logic [15:0] tx_ethertype,
	output logic        fifo_rd,
	input  logic [7:0]  fifo_data,
	input  logic        fifo_empty,
	input  logic [31:0] crc,
	output logic        crc_en,
	output logic        crc_clear,
	output logic [7:0]  gmii_txd,
	output logic        gmii_tx_en,
	output logic        gmii_tx_er,
	output logic        tx_busy
);
	import eth_pkg::*;

	localparam int HW = 8 * HEADER_LEN;

	tx_state_t state;
	tx_state_t state_next;
	logic [7:0] cnt;
	logic tx_valid_q;
	logic tx_valid_q2;
	logic rd_q;
	logic [HW-1:0] hdr;
	logic [7:0] txd_q;

	always_comb begin
		state_next = state;
		case (state)
			TX_IDLE: if (tx_valid_q && !tx_valid_q2) state_next = TX_PREAMBLE;
			TX_PREAMBLE: if (cnt == PREAMBLE_LEN - 1) state_next = TX_HEADER;
			TX_HEADER: if (cnt == HEADER_LEN - 1) state_next = TX_PAYLOAD;
			TX_PAYLOAD: if (cnt >= MIN_PAYLOAD - 1 && !rd_q) state_next = TX_FCS;
			TX_FCS: if (cnt == FCS_LEN - 1) state_next = TX_GAP;
			TX_GAP: if (cnt == GAP_LEN - 1) state_next = TX_IDLE;
			default: state_next = TX_IDLE;
		endcase
	end

	// Reads run two cycles ahead of the wire.
	assign fifo_rd = !fifo_empty &&
		((state == TX_HEADER && cnt >= HEADER_LEN - 2) || state == TX_PAYLOAD);

	assign crc_en = (state == TX_HEADER) || (state == TX_PAYLOAD);
	assign crc_clear = (state == TX_IDLE) || (state == TX_PREAMBLE);

	// CRC register holds still during FCS.
	assign gmii_txd = (state == TX_FCS) ? crc[{cnt[1:0], 3'b000} +: 8] : txd_q;
	assign gmii_tx_en = (state != TX_IDLE) && (state != TX_GAP);
	assign gmii_tx_er = 1'b0;
	assign tx_busy = (state != TX_IDLE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= TX_IDLE;
			cnt <= '0;
			tx_valid_q <= 1'b0;
			tx_valid_q2 <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			state <= state_next;
			cnt <= (state_next == state) ? cnt + 8'd1 : 8'd0;
			tx_valid_q <= tx_valid;
			tx_valid_q2 <= tx_valid_q;
			rd_q <= fifo_rd; // FIFO data valid next cycle.
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			TX_IDLE: begin
				if (tx_valid && !tx_valid_q)
					hdr <= {tx_dmac, tx_smac, tx_ethertype};
				txd_q <= (state_next == TX_PREAMBLE) ? PREAMBLE_BYTE : 8'h00;
			end
			TX_PREAMBLE: begin
				if (cnt == PREAMBLE_LEN - 1) begin
					txd_q <= hdr[HW-1 -: 8];
					hdr <= {hdr[HW-9:0], 8'h00};
				end else if (cnt == PREAMBLE_LEN - 2) begin
					txd_q <= SFD_BYTE;
				end else begin
					txd_q <= PREAMBLE_BYTE;
				end
			end
			TX_HEADER: begin
				if (cnt == HEADER_LEN - 1) begin
					txd_q <= rd_q ? fifo_data : 8'h00;
				end else begin
					txd_q <= hdr[HW-1 -: 8];
					hdr <= {hdr[HW-9:0], 8'h00};
				end
			end
			TX_PAYLOAD: txd_q <= rd_q ? fifo_data : 8'h00; // Zero pad.
			default: txd_q <= 8'h00;
		endcase
	end

endmodule

`default_nettype wire

/* gmii_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module gmii_rx (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  gmii_rxd,
	input  logic        gmii_rx_dv,
	input  logic        gmii_rx_er,
	output logic [7:0]  crc_byte,
	output logic        crc_en,
	output logic        crc_clear,
	input  logic        residue_ok,
	output logic [47:0] rx_dmac,
	output logic [47:0] rx_smac,
	output logic [15:0] rx_ethertype,
	output logic        rx_header_valid,
	output logic [7:0]  rx_data,
	output logic        rx_valid,
	output logic        rx_error,
	output logic        rx_frame_end,
	output logic        rx_crc_ok,
	output logic        rx_busy
);
	import eth_pkg::*;

	rx_state_t state;
	rx_state_t state_next;
	logic [3:0] cnt;
	logic [7:0] rxd_q;
	logic dv_q;
	logic er_q;
	logic [8*HEADER_LEN-1:0] hdr;
	logic byte_in;

	always_comb begin
		state_next = state;
		case (state)
			RX_IDLE: if (dv_q) state_next = RX_PREAMBLE; // Carrier seen.
			RX_PREAMBLE: begin
				if (!dv_q)
					state_next = RX_IDLE;
				else if (rxd_q == SFD_BYTE)
					state_next = RX_HEADER;
			end
			RX_HEADER: if (cnt == HEADER_LEN - 1) state_next = RX_PAYLOAD;
			RX_PAYLOAD: if (!dv_q) state_next = RX_TAIL;
			RX_TAIL: state_next = RX_GAP;
			RX_GAP: if (cnt == GAP_LEN - 1) state_next = RX_IDLE;
			default: state_next = RX_IDLE;
		endcase
	end

	assign byte_in = (state == RX_HEADER) || (state == RX_PAYLOAD && dv_q);
	assign crc_byte = rxd_q;
	assign crc_en = byte_in;
	assign crc_clear = (state == RX_IDLE) || (state == RX_PREAMBLE);

	assign {rx_dmac, rx_smac, rx_ethertype} = hdr;
	assign rx_busy = (state != RX_IDLE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= RX_IDLE;
			cnt <= '0;
			dv_q <= 1'b0;
			er_q <= 1'b0;
			rx_header_valid <= 1'b0;
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
			rx_frame_end <= 1'b0;
		end else begin
			state <= state_next;
			cnt <= (state_next == state) ? cnt + 4'd1 : 4'd0;
			dv_q <= gmii_rx_dv;
			er_q <= gmii_rx_er;
			rx_header_valid <= (state == RX_HEADER) && (cnt == HEADER_LEN - 1);
			rx_valid <= (state == RX_PAYLOAD) && dv_q;
			rx_error <= er_q && byte_in;
			rx_frame_end <= (state_next == RX_TAIL);
		end
	end

	always_ff @(posedge clk) begin
		rxd_q <= gmii_rxd;
		rx_data <= rxd_q;
		if (state == RX_HEADER)
			hdr <= {hdr[8*HEADER_LEN-9:0], rxd_q}; // First byte ends on top.
		if (state_next == RX_TAIL)
			rx_crc_ok <= residue_ok; // Last FCS byte already folded in.
	end

endmodule

`default_nettype wire

/* eth_gmii_mac.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_gmii_mac #(
	parameter int FIFO_AW = 5
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [47:0] tx_dmac,
	input  logic [47:0] tx_smac,
	input  logic [15:0] tx_ethertype,
	input  logic        tx_valid,
	input  logic [7:0]  tx_data,
	output logic        tx_busy,
	output logic [7:0]  gmii_txd,
	output logic        gmii_tx_en,
	output logic        gmii_tx_er,
	input  logic [7:0]  gmii_rxd,
	input  logic        gmii_rx_dv,
	input  logic        gmii_rx_er,
	output logic [47:0] rx_dmac,
	output logic [47:0] rx_smac,
	output logic [15:0] rx_ethertype,
	output logic        rx_header_valid,
	output logic [7:0]  rx_data,
	output logic        rx_valid,
	output logic        rx_error,
	output logic        rx_frame_end,
	output logic        rx_crc_ok,
	output logic        rx_busy
);

	logic       fifo_rd;
	logic [7:0] fifo_data;
	logic       fifo_empty;
	logic [31:0] tx_crc;
	logic       tx_crc_en;
	logic       tx_crc_clear;
	logic [7:0] rx_crc_byte;
	logic       rx_crc_en;
	logic       rx_crc_clear;
	logic       rx_residue_ok;

	tx_fifo #(
		.FIFO_AW(FIFO_AW)
	) i_tx_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(tx_valid),
		.wr_data(tx_data),
		.rd_en(fifo_rd),
		.rd_data(fifo_data),
		.empty(fifo_empty)
	);

	gmii_tx i_gmii_tx (
		.clk(clk),
		.reset(reset),
		.tx_valid(tx_valid),
		.tx_dmac(tx_dmac),
		.tx_smac(tx_smac),
		.tx_ethertype(tx_ethertype),
		.fifo_rd(fifo_rd),
		.fifo_data(fifo_data),
		.fifo_empty(fifo_empty),
		.crc(tx_crc),
		.crc_en(tx_crc_en),
		.crc_clear(tx_crc_clear),
		.gmii_txd(gmii_txd),
		.gmii_tx_en(gmii_tx_en),
		.gmii_tx_er(gmii_tx_er),
		.tx_busy(tx_busy)
	);

	crc32_d8 i_tx_crc (
		.clk(clk),
		.reset(reset),
		.clear(tx_crc_clear),
		.en(tx_crc_en),
		.d(gmii_txd), // Sees the bytes as sent.
		.crc(tx_crc),
		.residue_ok()
	);

	gmii_rx i_gmii_rx (
		.clk(clk),
		.reset(reset),
		.gmii_rxd(gmii_rxd),
		.gmii_rx_dv(gmii_rx_dv),
		.gmii_rx_er(gmii_rx_er),
		.crc_byte(rx_crc_byte),
		.crc_en(rx_crc_en),
		.crc_clear(rx_crc_clear),
		.residue_ok(rx_residue_ok),
		.rx_dmac(rx_dmac),
		.rx_smac(rx_smac),
		.rx_ethertype(rx_ethertype),
		.rx_header_valid(rx_header_valid),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_error(rx_error),
		.rx_frame_end(rx_frame_end),
		.rx_crc_ok(rx_crc_ok),
		.rx_busy(rx_busy)
	);

	crc32_d8 i_rx_crc (
		.clk(clk),
		.reset(reset),
		.clear(rx_crc_clear),
		.en(rx_crc_en),
		.d(rx_crc_byte),
		.crc(),
		.residue_ok(rx_residue_ok)
	);

endmodule

`default_nettype wire

/* eth_gmii_mac_props.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_gmii_mac_props (
	input logic clk,
	input logic reset,
	input logic gmii_tx_en,
	input logic gmii_tx_er,
	input logic tx_busy,
	input logic rx_valid,
	input logic rx_busy,
	input logic rx_frame_end
);

	a_tx_en_busy: assert property (@(posedge clk) disable iff (reset)
		gmii_tx_en |-> tx_busy)
		else $error("gmii_tx_en is high while tx_busy is low");

	a_frame_end_pulse: assert property (@(posedge clk) disable iff (reset)
		rx_frame_end |=> !rx_frame_end)
		else $error("rx_frame_end lasted more than one cycle");

	a_rx_valid_busy: assert property (@(posedge clk) disable iff (reset)
		rx_valid |-> rx_busy)
		else $error("rx_valid is high while rx_busy is low");

	a_tx_er_low: assert property (@(posedge clk) disable iff (reset)
		!gmii_tx_er)
		else $error("gmii_tx_er went high");

endmodule

bind eth_gmii_mac eth_gmii_mac_props i_eth_gmii_mac_props (
	.clk(clk),
	.reset(reset),
	.gmii_tx_en(gmii_tx_en),
	.gmii_tx_er(gmii_tx_er),
	.tx_busy(tx_busy),
	.rx_valid(rx_valid),
	.rx_busy(rx_busy),
	.rx_frame_end(rx_frame_end)
);

`default_nettype wire

/* tb_eth_gmii_mac.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_eth_gmii_mac;

	localparam int NUM_FRAMES = 40;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 200;

	logic clk = 1'b0;
	logic reset;
	logic [47:0] tx_dmac;
	logic [47:0] tx_smac;
	logic [15:0] tx_ethertype;
	logic tx_valid;
	logic [7:0] tx_data;
	logic tx_busy;
	logic [7:0] gmii_txd;
	logic gmii_tx_en;
	logic gmii_tx_er;
	logic [7:0] gmii_rxd;
	logic gmii_rx_dv;
	logic gmii_rx_er = 1'b0;
	logic [47:0] rx_dmac;
	logic [47:0] rx_smac;
	logic [15:0] rx_ethertype;
	logic rx_header_valid;
	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_error;
	logic rx_frame_end;
	logic rx_crc_ok;
	logic rx_busy;

	logic [31:0] rng_state = 32'd1;
	int cycle = 0;
	int fail_count = 0;
	int start_cycle;
	logic [7:0] pay_q[$];
	logic [7:0] wire_q[$]; // Frame as the transmitter must send it.
	logic [7:0] rx_q[$]; // Same frame after the loopback flip.
	logic flip_on;
	int unsigned flip_idx;
	int unsigned flip_bit;
	logic [7:0] flip_mask = 8'h00;
	int en_count = 0;

	eth_gmii_mac #(
		.FIFO_AW(5)
	) i_eth_gmii_mac (
		.clk(clk),
		.reset(reset),
		.tx_dmac(tx_dmac),
		.tx_smac(tx_smac),
		.tx_ethertype(tx_ethertype),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.gmii_txd(gmii_txd),
		.gmii_tx_en(gmii_tx_en),
		.gmii_tx_er(gmii_tx_er),
		.gmii_rxd(gmii_rxd),
		.gmii_rx_dv(gmii_rx_dv),
		.gmii_rx_er(gmii_rx_er),
		.rx_dmac(rx_dmac),
		.rx_smac(rx_smac),
		.rx_ethertype(rx_ethertype),
		.rx_header_valid(rx_header_valid),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_error(rx_error),
		.rx_frame_end(rx_frame_end),
		.rx_crc_ok(rx_crc_ok),
		.rx_busy(rx_busy)
	);

	assign gmii_rxd = gmii_txd ^ flip_mask; // Loopback with optional bit flip.
	assign gmii_rx_dv = gmii_tx_en;

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run went past %0d cycles without finishing.", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "Simulation stopped on timeout.");
		end
	end

	// Counts wire bytes and corrupts the chosen byte with rx_er set.
	always @(posedge clk) begin
		#1;
		if (gmii_tx_en) begin
			flip_mask = (flip_on && en_count == flip_idx) ? (8'h01 << flip_bit) : 8'h00;
			gmii_rx_er = flip_on && (en_count == flip_idx);
			en_count = en_count + 1;
		end else begin
			flip_mask = 8'h00;
			gmii_rx_er = 1'b0;
			en_count = 0;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Bit-serial reflected CRC-32, one data bit at a time.
	function automatic logic [31:0] crc_add_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		logic fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[0] ^ b[i];
			r = r >> 1;
			if (fb)
				r = r ^ 32'hEDB88320;
		end
		return r;
	endfunction

	task automatic stop_run();
		fail_count++;
		$display("TESTS FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %02h, actual %02h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_mac(input string name, input logic [47:0] exp, input logic [47:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %012h, actual %012h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_type(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %04h, actual %04h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic build_frame();
		int unsigned n;
		int unsigned padded;
		logic [31:0] crc;
		logic [7:0] b;
		pay_q.delete();
		wire_q.delete();
		tx_dmac[47:16] = next_random();
		tx_dmac[15:0] = next_random() >> 16;
		tx_smac[47:16] = next_random();
		tx_smac[15:0] = next_random() >> 16;
		tx_ethertype = next_random() >> 16;
		n = 1 + (next_random() >> 8) % 100;
		for (int i = 0; i < n; i++)
			pay_q.push_back(next_random() >> 24);
		padded = (n < 46) ? 46 : n;
		repeat (7) wire_q.push_back(8'h55);
		wire_q.push_back(8'hD5);
		crc = 32'hFFFFFFFF;
		for (int i = 0; i < 14; i++) begin
			if (i < 6)
				b = tx_dmac[8 * (5 - i) +: 8]; // Network order.
			else if (i < 12)
				b = tx_smac[8 * (11 - i) +: 8];
			else
				b = tx_ethertype[8 * (13 - i) +: 8];
			wire_q.push_back(b);
			crc = crc_add_byte(crc, b);
		end
		for (int i = 0; i < padded; i++) begin
			b = (i < n) ? pay_q[i] : 8'h00;
			wire_q.push_back(b);
			crc = crc_add_byte(crc, b);
		end
		crc = ~crc;
		for (int i = 0; i < 4; i++)
			wire_q.push_back(crc[8 * i +: 8]); // LSB first.
		flip_on = ((next_random() >> 12) % 4) == 0;
		flip_idx = 8 + (next_random() >> 8) % (wire_q.size() - 8);
		flip_bit = (next_random() >> 20) % 8;
		rx_q = wire_q;
		if (flip_on)
			rx_q[flip_idx] = rx_q[flip_idx] ^ (8'h01 << flip_bit);
	endtask

	task automatic send_payload();
		@(posedge clk);
		#1;
		start_cycle = cycle;
		for (int i = 0; i < pay_q.size(); i++) begin
			tx_valid = 1'b1;
			tx_data = pay_q[i];
			@(posedge clk);
			#1;
		end
		tx_valid = 1'b0;
		tx_data = 8'h00;
	endtask

	task automatic watch_tx();
		int i;
		int gap;
		@(negedge clk);
		while (!gmii_tx_en) begin
			check_flag("tx_busy before frame", 1'b0, tx_busy);
			@(negedge clk);
		end
		check_count("tx start latency", 2, cycle - start_cycle);
		check_flag("tx_busy at first byte", 1'b1, tx_busy);
		i = 0;
		while (gmii_tx_en) begin
			if (i < wire_q.size())
				check_byte($sformatf("tx byte %0d", i), wire_q[i], gmii_txd);
			i++;
			@(negedge clk);
		end
		check_count("tx_en length", wire_q.size(), i);
		gap = 0;
		while (tx_busy) begin
			gap++;
			@(negedge clk);
		end
		check_count("tx gap", 12, gap);
	endtask

	task automatic watch_rx();
		int k;
		int headers;
		int errors;
		logic done;
		k = 0;
		headers = 0;
		errors = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (rx_error)
				errors++;
			if (rx_header_valid) begin
				check_mac("rx_dmac", {rx_q[8], rx_q[9], rx_q[10], rx_q[11], rx_q[12], rx_q[13]},
					rx_dmac);
				check_mac("rx_smac", {rx_q[14], rx_q[15], rx_q[16], rx_q[17], rx_q[18], rx_q[19]},
					rx_smac);
				check_type("rx_ethertype", {rx_q[20], rx_q[21]}, rx_ethertype);
				headers++;
			end
			if (rx_valid) begin
				if (22 + k < rx_q.size())
					check_byte($sformatf("rx byte %0d", k), rx_q[22 + k], rx_data);
				check_flag($sformatf("rx_error at byte %0d", k),
					flip_on && (22 + k == flip_idx), rx_error);
				k++;
			end
			if (rx_frame_end) begin
				check_flag("rx_crc_ok", !flip_on, rx_crc_ok);
				done = 1'b1;
			end
		end
		check_count("rx header pulses", 1, headers);
		check_count("rx byte count", rx_q.size() - 22, k);
		check_count("rx_error pulses", flip_on ? 1 : 0, errors);
		while (rx_busy)
			@(negedge clk);
	endtask

	initial begin
		reset = 1'b1;
		tx_dmac = '0;
		tx_smac = '0;
		tx_ethertype = '0;
		tx_valid = 1'b0;
		tx_data = 8'h00;
		flip_on = 1'b0;
		flip_idx = 0;
		flip_bit = 0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_flag("gmii_tx_en after reset", 1'b0, gmii_tx_en);
		check_flag("tx_busy after reset", 1'b0, tx_busy);
		check_flag("rx_valid after reset", 1'b0, rx_valid);
		check_flag("rx_header_valid after reset", 1'b0, rx_header_valid);
		check_flag("rx_frame_end after reset", 1'b0, rx_frame_end);
		check_flag("rx_busy after reset", 1'b0, rx_busy);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			build_frame();
			fork
				send_payload();
				watch_tx();
				watch_rx();
			join
			repeat (2) @(posedge clk);
			#1;
		end
		if (fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
eth_pkg.sv
crc32_d8.sv
tx_fifo.sv
gmii_tx.sv
gmii_rx.sv
eth_gmii_mac.sv
eth_gmii_mac_props.sv
tb_eth_gmii_mac.sv

/* Bender.yml */
package:
  name: eth_gmii_mac

sources:
  - eth_pkg.sv
  - crc32_d8.sv
  - tx_fifo.sv
  - gmii_tx.sv
  - gmii_rx.sv
  - eth_gmii_mac.sv
  - target: test
    files:
      - eth_gmii_mac_props.sv
      - tb_eth_gmii_mac.sv
